//--- design/accum_defines.svh
`ifndef ACCUM_DEFINES_SVH
`define ACCUM_DEFINES_SVH

// Command operand, zero-extended into the accumulator
`define ACC_OPERAND_WIDTH 16

// Accumulator and reported value, wraps modulo 2^24
`define ACC_VALUE_WIDTH 24

`define ACC_TAG_WIDTH 8      // Report sequence number, wraps at 256

// Queue depths, powers of two
`define ACC_CMD_DEPTH 8
`define ACC_RSP_DEPTH 4

`endif

//--- design/accum_engine.sv
`timescale 1ns/1ps
`include "accum_defines.svh"

// Two-stage accumulator engine
// Issue pops the command FIFO, execute applies the popped entry a cycle later

module accum_engine (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 flush,
    input  logic                                 cmd_empty,
    input  cmd_pkg::cmd_t                        cmd_q,
    input  logic [$clog2(`ACC_RSP_DEPTH+1)-1:0]  rsp_usedw,
    output logic                                 cmd_rdreq,
    output logic                                 rsp_wrreq,
    output rsp_pkg::rsp_t                        rsp_data
);

    localparam int USEDW_WIDTH = $clog2(`ACC_RSP_DEPTH + 1);

    logic                          exec_valid;      // cmd_q holds a fresh entry
    logic                          exec_report;
    logic [USEDW_WIDTH:0]          rsp_committed;
    logic [`ACC_VALUE_WIDTH-1:0]   operand_ext;
    logic [`ACC_VALUE_WIDTH-1:0]   acc;
    rsp_pkg::tag_t                 tag;

    // Report sitting in execute, not yet counted by usedw
    assign exec_report = exec_valid && (cmd_q.op == cmd_pkg::op_report);

    // Result slots taken or promised
    assign rsp_committed = {1'b0, rsp_usedw} + (USEDW_WIDTH + 1)'(exec_report);

    // Issue does not look at the opcode, so every pop needs a free result slot
    assign cmd_rdreq = !cmd_empty && !flush && (rsp_committed < `ACC_RSP_DEPTH);

    // Execute stage valid
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= cmd_rdreq;     // rdreq already implies not empty
        end
    end

    assign operand_ext = `ACC_VALUE_WIDTH'(cmd_q.operand);

    // Accumulator and tag counter
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            acc <= '0;
            tag <= '0;
        end else if (exec_valid) begin
            case (cmd_q.op)
                cmd_pkg::op_clear: begin
                    acc <= '0;
                end
                cmd_pkg::op_add: begin
                    acc <= acc + operand_ext;     // Wraps
                end
                cmd_pkg::op_sub: begin
                    acc <= acc - operand_ext;
                end
                cmd_pkg::op_report: begin
                    tag <= tag + 1'b1;     // Next report number
                end
                default: begin
                    acc <= acc;
                end
            endcase
        end
    end

    // Report carries the value before this edge and the current tag
    assign rsp_wrreq = exec_report;
    assign rsp_data  = '{tag: tag, value: acc};

    // Space reservation at issue must hold by the time the report is written
    assert property (@(posedge clock) disable iff (reset || flush)
        rsp_wrreq |-> (rsp_usedw != USEDW_WIDTH'(`ACC_RSP_DEPTH)))
        else $error("accum_engine: report written into full result FIFO");

endmodule

//--- design/accum_top.sv
`timescale 1ns/1ps
`include "accum_defines.svh"

// Command FIFO -> engine -> result FIFO

module accum_top (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            cmd_wrreq,
    input  cmd_pkg::cmd_op_t                cmd_op,
    input  logic [`ACC_OPERAND_WIDTH-1:0]   cmd_operand,
    input  logic                            rsp_rdreq,
    output logic                            cmd_full,
    output logic                            rsp_empty,
    output rsp_pkg::tag_t                   rsp_tag,
    output logic [`ACC_VALUE_WIDTH-1:0]     rsp_value
);

    cmd_pkg::cmd_t                                cmd_data;
    cmd_pkg::cmd_t                                cmd_q;
    logic                                         cmd_empty;
    logic                                         cmd_rdreq;

    rsp_pkg::rsp_t                                rsp_data;
    rsp_pkg::rsp_t                                rsp_q;
    logic                                         rsp_wrreq;
    logic [$clog2(`ACC_RSP_DEPTH+1)-1:0]          rsp_usedw;

    assign cmd_data = '{op: cmd_op, operand: cmd_operand};

    // Incoming commands
    scfifo #(
        .payload_t (cmd_pkg::cmd_t),
        .DEPTH     (`ACC_CMD_DEPTH)
    ) cmd_fifo (
        .clock (clock),
        .reset (reset),
        .sclr  (flush),
        .data  (cmd_data),
        .wrreq (cmd_wrreq),
        .rdreq (cmd_rdreq),
        .q     (cmd_q),
        .empty (cmd_empty),
        .full  (cmd_full),
        .usedw ()
    );

    accum_engine engine (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .cmd_empty (cmd_empty),
        .cmd_q     (cmd_q),
        .rsp_usedw (rsp_usedw),
        .cmd_rdreq (cmd_rdreq),
        .rsp_wrreq (rsp_wrreq),
        .rsp_data  (rsp_data)
    );

    // Outgoing reports, full is never needed since the engine reserves space
    scfifo #(
        .payload_t (rsp_pkg::rsp_t),
        .DEPTH     (`ACC_RSP_DEPTH)
    ) rsp_fifo (
        .clock (clock),
        .reset (reset),
        .sclr  (flush),
        .data  (rsp_data),
        .wrreq (rsp_wrreq),
        .rdreq (rsp_rdreq),
        .q     (rsp_q),
        .empty (rsp_empty),
        .full  (),
        .usedw (rsp_usedw)
    );

    assign rsp_tag   = rsp_q.tag;
    assign rsp_value = rsp_q.value;

endmodule

//--- design/cmd_pkg.sv
`include "accum_defines.svh"

// Command side of the accumulator

package cmd_pkg;

    // Opcode set of the engine
    typedef enum logic [1:0] {
        op_clear  = 2'd0,    // Accumulator to zero
        op_add    = 2'd1,    // Add operand
        op_sub    = 2'd2,    // Subtract operand
        op_report = 2'd3     // Push accumulator with tag
    } cmd_op_t;

    // Command FIFO payload, 18 bits
    typedef struct packed {
        cmd_op_t                        op;
        logic [`ACC_OPERAND_WIDTH-1:0]  operand;     // Ignored by clear and report
    } cmd_t;

endpackage

//--- design/rsp_pkg.sv
`include "accum_defines.svh"

// Result side of the accumulator

package rsp_pkg;

    // Sequence number of a report
    typedef logic [`ACC_TAG_WIDTH-1:0] tag_t;

    // Result FIFO payload, 32 bits
    typedef struct packed {
        tag_t                         tag;
        logic [`ACC_VALUE_WIDTH-1:0]  value;     // Accumulator at report time
    } rsp_t;

endpackage

//--- design/scfifo.sv
`timescale 1ns/1ps

// Single-clock FIFO with registered output
// q is loaded at the edge that accepts a read and holds otherwise
// DEPTH is expected to be a power of two

module scfifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        sclr,
    input  payload_t                    data,
    input  logic                        wrreq,
    input  logic                        rdreq,
    output payload_t                    q,
    output logic                        empty,
    output logic                        full,
    output logic [$clog2(DEPTH+1)-1:0]  usedw
);

    localparam int ADDR_WIDTH  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int PTR_WIDTH   = ADDR_WIDTH + 1;     // Extra wrap bit
    localparam int USEDW_WIDTH = $clog2(DEPTH + 1);

    payload_t                mem [DEPTH];

    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [PTR_WIDTH-1:0]    wr_ptr_next;
    logic [PTR_WIDTH-1:0]    rd_ptr_next;
    logic [PTR_WIDTH-1:0]    fill_next;
    logic                    wr_en;
    logic                    rd_en;

    // Accepted operations, judged on the current flags
    assign wr_en = wrreq && !full;
    assign rd_en = rdreq && !empty;

    assign wr_ptr_next = wr_ptr + PTR_WIDTH'(wr_en);
    assign rd_ptr_next = rd_ptr + PTR_WIDTH'(rd_en);

    // Occupancy after this edge, wrap bit makes the difference exact
    assign fill_next = wr_ptr_next - rd_ptr_next;

    // Storage
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= data;
        end
    end

    // Pointers and status, flags follow the next pointer state
    always_ff @(posedge clock) begin
        if (reset || sclr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
            usedw  <= '0;
        end else begin
            wr_ptr <= wr_ptr_next;
            rd_ptr <= rd_ptr_next;
            empty  <= (fill_next == '0);
            full   <= (fill_next == PTR_WIDTH'(DEPTH));
            usedw  <= USEDW_WIDTH'(fill_next);
        end
    end

    // Registered read data
    always_ff @(posedge clock) begin
        if (reset || sclr) begin
            q <= '0;
        end else if (rd_en) begin
            q <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // Flags must agree with each other across every sequence of operations
    assert property (@(posedge clock) disable iff (reset)
        !(empty && full))
        else $error("scfifo: empty and full both high");

    // Occupancy never runs past the storage
    assert property (@(posedge clock) disable iff (reset)
        usedw <= USEDW_WIDTH'(DEPTH))
        else $error("scfifo: usedw %0d above depth %0d", usedw, DEPTH);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the accumulator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module accum_tb \
    -Mdir obj_dir

sim_output=$(./obj_dir/Vaccum_tb)
echo "$sim_output"

if grep -q "Testbench passed" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

//--- sim/accum_tb.sv
`timescale 1ns/1ps
`include "accum_defines.svh"

module accum_tb;

    localparam int TOTAL_COMMANDS  = 371;     // Commands written over all five tests
    localparam int WATCHDOG_CYCLES = TOTAL_COMMANDS * 20 + 2000;

    logic                            clock;
    logic                            reset;
    logic                            flush;
    logic                            cmd_wrreq;
    cmd_pkg::cmd_op_t                cmd_op;
    logic [`ACC_OPERAND_WIDTH-1:0]   cmd_operand;
    logic                            rsp_rdreq;
    logic                            cmd_full;
    logic                            rsp_empty;
    rsp_pkg::tag_t                   rsp_tag;
    logic [`ACC_VALUE_WIDTH-1:0]     rsp_value;

    // Reference model state
    logic [`ACC_VALUE_WIDTH-1:0]     model_acc;
    rsp_pkg::tag_t                   model_tag;
    rsp_pkg::rsp_t                   expected_q [$];

    logic                            read_enable;
    logic                            probe_read;      // Strobe rdreq even when empty
    logic                            enable_now;
    logic                            probe_now;
    logic                            read_live;       // Read accepted at the coming edge

    int                              seed;
    int                              error_count;
    int                              check_count;
    int                              test_count;
    int                              test_fail_count;
    int                              errors_at_start;

    accum_top accum_top_i (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .cmd_wrreq   (cmd_wrreq),
        .cmd_op      (cmd_op),
        .cmd_operand (cmd_operand),
        .rsp_rdreq   (rsp_rdreq),
        .cmd_full    (cmd_full),
        .rsp_empty   (rsp_empty),
        .rsp_tag     (rsp_tag),
        .rsp_value   (rsp_value)
    );

    always #5 clock = ~clock;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Simulation timed out after %0d cycles, a test is stuck waiting", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // Steps the model by one command and queues any report
    function automatic void model_step(input cmd_pkg::cmd_op_t op,
                                       input logic [`ACC_OPERAND_WIDTH-1:0] operand);
        logic [`ACC_VALUE_WIDTH-1:0] operand_ext;
        rsp_pkg::rsp_t               rsp;
        operand_ext = {{(`ACC_VALUE_WIDTH - `ACC_OPERAND_WIDTH){1'b0}}, operand};
        case (op)
            cmd_pkg::op_clear: begin
                model_acc = '0;
            end
            cmd_pkg::op_add: begin
                model_acc = model_acc + operand_ext;     // Modulo 2^24
            end
            cmd_pkg::op_sub: begin
                model_acc = model_acc - operand_ext;
            end
            default: begin
                rsp.tag   = model_tag;
                rsp.value = model_acc;
                expected_q.push_back(rsp);
                model_tag = model_tag + 8'd1;     // Wraps at 256
            end
        endcase
    endfunction

    function automatic logic [`ACC_OPERAND_WIDTH-1:0] random_operand();
        logic [31:0] r;
        r = $random(seed);
        return r[`ACC_OPERAND_WIDTH-1:0];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    task automatic check_report();
        rsp_pkg::rsp_t exp_rsp;
        if (expected_q.size() == 0) begin
            error_count++;
            $display("At %0t a report arrived with tag %0d while none was expected",
                     $time, rsp_tag);
        end else begin
            exp_rsp = expected_q.pop_front();
            check_value("report tag", 32'(rsp_tag), 32'(exp_rsp.tag));
            check_value("report value", 32'(rsp_value), 32'(exp_rsp.value));
        end
    endtask

    // Reader compares q one edge after the accepted read
    always begin
        @(posedge clock);
        enable_now = read_enable;
        probe_now  = probe_read;
        #1;
        if (read_live) begin
            check_report();
        end
        rsp_rdreq = probe_now || (enable_now && !rsp_empty);
        read_live = rsp_rdreq && !rsp_empty;
    end

    // One-cycle write strobe that ignores cmd_full
    task automatic drive_command(input cmd_pkg::cmd_op_t op,
                                 input logic [`ACC_OPERAND_WIDTH-1:0] operand);
        cmd_wrreq   = 1'b1;
        cmd_op      = op;
        cmd_operand = operand;
        @(posedge clock);
        #1;
        cmd_wrreq = 1'b0;
    endtask

    task automatic send_command(input cmd_pkg::cmd_op_t op,
                                input logic [`ACC_OPERAND_WIDTH-1:0] operand);
        while (cmd_full) begin
            @(posedge clock);
            #1;
        end
        model_step(op, operand);
        drive_command(op, operand);
    endtask

    task automatic wait_drained();
        @(posedge clock);
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end
        #1;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count - errors_at_start;
        test_count++;
        if (errors == 0) begin
            $display("Test %0d, %s: ok", test_count, name);
        end else begin
            test_fail_count++;
            $display("Test %0d, %s: %0d errors", test_count, name, errors);
        end
    endtask

    task automatic test_after_reset();
        start_test();
        check_value("rsp_empty after reset", 32'(rsp_empty), 32'd1);
        check_value("cmd_full after reset", 32'(cmd_full), 32'd0);
        probe_read = 1'b1;
        repeat (4) begin
            @(posedge clock);
            #1;
            check_value("rsp_empty under read strobe", 32'(rsp_empty), 32'd1);
            check_value("rsp_tag under read strobe", 32'(rsp_tag), 32'd0);
            check_value("rsp_value under read strobe", 32'(rsp_value), 32'd0);
        end
        probe_read = 1'b0;
        @(posedge clock);
        #1;
        finish_test("after reset");
    endtask

    // Mostly reports so the tag wraps with arithmetic every seventh command
    task automatic test_random_stream();
        logic [31:0]      r;
        cmd_pkg::cmd_op_t op;
        start_test();
        read_enable = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            if (i % 7 == 3) begin
                case (r[2:0])
                    3'd0:    op = cmd_pkg::op_clear;
                    3'd1,
                    3'd2,
                    3'd3,
                    3'd4:    op = cmd_pkg::op_add;
                    default: op = cmd_pkg::op_sub;     // Often takes acc below zero
                endcase
            end else begin
                op = cmd_pkg::op_report;
            end
            send_command(op, r[31:32-`ACC_OPERAND_WIDTH]);
        end
        wait_drained();
        finish_test("random command stream");
    endtask

    task automatic test_back_pressure();
        start_test();
        read_enable = 1'b0;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    send_command(cmd_pkg::op_add, random_operand());
                    send_command(cmd_pkg::op_report, '0);
                end
            end
            begin
                while (!cmd_full) begin
                    @(posedge clock);
                    #1;
                end
                read_enable = 1'b1;     // Both queues backed up
            end
        join
        wait_drained();
        finish_test("back-pressure");
    endtask

    task automatic test_dropped_write();
        start_test();
        read_enable = 1'b0;
        repeat (`ACC_RSP_DEPTH) begin
            send_command(cmd_pkg::op_report, '0);
        end
        // These stay queued while the full result FIFO stalls the engine
        send_command(cmd_pkg::op_add, random_operand());
        send_command(cmd_pkg::op_sub, random_operand());
        send_command(cmd_pkg::op_add, random_operand());
        send_command(cmd_pkg::op_clear, random_operand());
        send_command(cmd_pkg::op_add, random_operand());
        send_command(cmd_pkg::op_add, random_operand());
        send_command(cmd_pkg::op_sub, random_operand());
        send_command(cmd_pkg::op_report, '0);
        check_value("cmd_full with command FIFO loaded", 32'(cmd_full), 32'd1);
        drive_command(cmd_pkg::op_add, 16'h1234);     // Model never sees this one
        check_value("cmd_full after ignored write", 32'(cmd_full), 32'd1);
        read_enable = 1'b1;
        wait_drained();
        send_command(cmd_pkg::op_report, '0);
        wait_drained();
        finish_test("write while full");
    endtask

    task automatic test_flush();
        start_test();
        read_enable = 1'b0;
        send_command(cmd_pkg::op_add, 16'h00aa);
        send_command(cmd_pkg::op_report, '0);
        send_command(cmd_pkg::op_add, random_operand());
        send_command(cmd_pkg::op_report, '0);
        send_command(cmd_pkg::op_report, '0);
        send_command(cmd_pkg::op_sub, random_operand());
        send_command(cmd_pkg::op_report, '0);
        send_command(cmd_pkg::op_report, '0);
        send_command(cmd_pkg::op_add, random_operand());
        // Two entries wait behind the stalled engine, six more fill the command FIFO
        repeat (6) begin
            send_command(cmd_pkg::op_add, random_operand());
        end
        check_value("rsp_empty before flush", 32'(rsp_empty), 32'd0);
        check_value("cmd_full before flush", 32'(cmd_full), 32'd1);
        pulse_flush();
        model_acc = '0;
        model_tag = '0;
        expected_q.delete();
        check_value("rsp_empty after flush", 32'(rsp_empty), 32'd1);
        check_value("cmd_full after flush", 32'(cmd_full), 32'd0);
        read_enable = 1'b1;
        send_command(cmd_pkg::op_add, 16'h0321);
        send_command(cmd_pkg::op_report, '0);     // Expect tag 0 with value 0x321
        wait_drained();
        finish_test("flush");
    endtask

    initial begin
        seed            = 73;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        test_fail_count = 0;
        errors_at_start = 0;
        clock           = 1'b0;
        reset           = 1'b1;
        flush           = 1'b0;
        cmd_wrreq       = 1'b0;
        cmd_op          = cmd_pkg::op_clear;
        cmd_operand     = '0;
        rsp_rdreq       = 1'b0;
        read_enable     = 1'b0;
        probe_read      = 1'b0;
        read_live       = 1'b0;
        model_acc       = '0;
        model_tag       = '0;

        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        test_after_reset();
        test_random_stream();
        test_back_pressure();
        test_dropped_write();
        test_flush();

        check_value("rsp_empty at end", 32'(rsp_empty), 32'd1);
        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 test_count, test_fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+design
design/cmd_pkg.sv
design/rsp_pkg.sv
design/scfifo.sv
design/accum_engine.sv
design/accum_top.sv
sim/accum_tb.sv
